// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove build output and the log"

test:
	verilator --binary --timing --timescale 1ns/1ps -f rs_div.f \
		--top-module rs_div_tb -Mdir obj_dir
	-./obj_dir/Vrs_div_tb | tee sim.log
	@if grep -q "^TEST OK$$" sim.log; then \
		echo "simulation passed"; \
	else \
		echo "simulation did not pass"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

// ==== dv/rs_div_tb.sv ====
`include "rs_div_cfg.svh"

module rs_div_tb import rs_div_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int K_DISP  = 0;
    localparam int K_WAKE  = 1;
    localparam int K_IDLE  = 2;
    localparam int K_FLUSH = 3;

    // wakeup source codes 0 to 3 follow the result buses
    localparam int W_ALU        = 0;
    localparam int W_MUL        = 1;
    localparam int W_DIV        = 2;
    localparam int W_MEM        = 3;
    localparam int W_MEM_NOREAD = 4;    // mem_tag driven, mem_read low
    localparam int W_NONE       = 5;

    typedef struct {
        int        kind;
        string     name;
        rs_entry_t ent;
        int        wsrc;
        phys_tag_t wtag;
        int        n;    // idle cycles
    } row_t;

    typedef struct {
        rs_entry_t e;
        logic      issued;
        string     name;
    } slot_t;

    logic             clk = 1'b0;
    logic             arst_n;
    logic             flush;
    logic             dispatch_valid;
    logic [`PC_W-1:0] dispatch_pc;
    phys_tag_t        dispatch_rd;
    logic [`OP_W-1:0] dispatch_aluop;
    phys_tag_t        dispatch_src1;
    phys_tag_t        dispatch_src2;
    logic             dispatch_rdy1;
    logic             dispatch_rdy2;
    logic             alu_valid;
    phys_tag_t        alu_tag;
    logic             mul_valid;
    phys_tag_t        mul_tag;
    logic             div_valid;
    phys_tag_t        div_tag;
    logic             mem_read;
    phys_tag_t        mem_tag;
    logic             rs_full;
    logic             issue_valid;
    logic [`PC_W-1:0] issue_pc;
    phys_tag_t        issue_rd;
    logic [`OP_W-1:0] issue_aluop;
    phys_tag_t        issue_src1;
    phys_tag_t        issue_src2;

    row_t      rows[$];
    slot_t     model_q[$];    // age order, oldest first
    rs_issue_t exp_q[$];
    string     exp_name[$];
    rs_issue_t act_issue;
    int        seed = 32'hf89d;

    rs_div_top i_rs_div_top (.*);

    always #5 clk = ~clk;

    assign act_issue = {issue_pc, issue_rd, issue_aluop, issue_src1, issue_src2};

    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_issue(string name, rs_issue_t exp, rs_issue_t act);
        if (act !== exp) begin
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_full(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("FAILED %s: expected rs_full %b, actual %b", name, exp, act);
            abort_run();
        end
    endtask

    function automatic phys_tag_t rand_tag();
        int v;
        v = $random(seed);
        return v[`TAG_W-1:0];
    endfunction

    task automatic add_row(int kind, string name, logic r1, logic r2, phys_tag_t s1,
                           phys_tag_t s2, int wsrc, phys_tag_t wtag, int n);
        row_t r;
        int   v;
        r.kind = kind;
        r.name = name;
        v = $random(seed);
        r.ent.op.pc = v;
        v = $random(seed);
        r.ent.op.rd    = v[`TAG_W-1:0];
        r.ent.op.aluop = v[`TAG_W+`OP_W-1:`TAG_W];
        r.ent.op.src1  = s1;
        r.ent.op.src2  = s2;
        r.ent.rdy1     = r1;
        r.ent.rdy2     = r2;
        r.wsrc = wsrc;
        r.wtag = wtag;
        r.n    = n;
        rows.push_back(r);
    endtask

    task automatic add_disp(string name, logic r1, logic r2, phys_tag_t s1, phys_tag_t s2);
        add_row(K_DISP, name, r1, r2, s1, s2, W_NONE, 8'h00, 1);
    endtask

    task automatic add_wake(string name, int src, phys_tag_t tag);
        add_row(K_WAKE, name, 1'b0, 1'b0, 8'h00, 8'h00, src, tag, 1);
    endtask

    task automatic add_idle(string name, int n);
        add_row(K_IDLE, name, 1'b0, 1'b0, 8'h00, 8'h00, W_NONE, 8'h00, n);
    endtask

    task automatic build_table();
        phys_tag_t t[4];
        phys_tag_t t_old;
        phys_tag_t t_c;
        phys_tag_t t_d;
        phys_tag_t t_fill;
        for (int i = 0; i < 4; i++) begin
            add_disp($sformatf("in_order_%0d", i), 1'b1, 1'b1, rand_tag(), rand_tag());
        end
        add_idle("in_order_drain", 8);
        for (int i = 0; i < 4; i++) begin
            t[i] = rand_tag();
            add_disp($sformatf("wake_bus_%0d", i), 1'b0, 1'b1, t[i], rand_tag());
        end
        add_idle("wake_pending", 6);
        for (int i = 0; i < 4; i++) begin
            add_wake("mem_no_read", W_MEM_NOREAD, t[i]);
        end
        add_idle("mem_no_read_quiet", 6);
        for (int i = 0; i < 4; i++) begin
            add_wake($sformatf("wake_bus_%0d_pulse", i), i, t[i]);    // alu, mul, div, mem
            add_idle($sformatf("wake_bus_%0d_drain", i), 6);
        end
        t_old = rand_tag();
        add_row(K_DISP, "same_cycle_bypass", 1'b0, 1'b1, t_old, rand_tag(), W_DIV, t_old, 1);
        add_idle("bypass_drain", 6);
        t_old = rand_tag();
        add_disp("older_blocked", 1'b0, 1'b1, t_old, rand_tag());
        add_disp("younger_ready", 1'b1, 1'b1, rand_tag(), rand_tag());
        add_idle("younger_first", 6);
        add_wake("older_wake", W_MUL, t_old);
        add_idle("older_after_wake", 8);
        t_c = rand_tag();
        t_d = rand_tag();
        add_disp("flushed_a", 1'b0, 1'b1, t_c, rand_tag());
        add_disp("flushed_b", 1'b1, 1'b0, rand_tag(), t_d);
        for (int i = 0; i < `RS_DEPTH - 2; i++) begin
            add_disp($sformatf("flushed_fill_%0d", i), 1'b0, 1'b1, t_c, rand_tag());
        end
        add_idle("before_flush", 6);
        add_row(K_FLUSH, "flush", 1'b0, 1'b0, 8'h00, 8'h00, W_NONE, 8'h00, 1);
        add_idle("after_flush", 6);
        add_wake("flushed_wake_a", W_ALU, t_c);
        add_wake("flushed_wake_b", W_DIV, t_d);
        add_idle("flushed_quiet", 8);
        t_fill = rand_tag();
        for (int i = 0; i < `RS_DEPTH; i++) begin
            add_disp($sformatf("fill_%0d", i), 1'b0, 1'b1, t_fill, rand_tag());
        end
        add_idle("fill_full", 6);
        add_disp("dropped_when_full", 1'b0, 1'b1, t_fill, rand_tag());
        add_idle("still_full", 6);
        add_wake("fill_wake", W_MEM, t_fill);
        add_idle("fill_drain", 26);    // one issue per cycle
        add_idle("final_drain", 8);
    endtask

    task automatic clear_inputs();
        flush          = 1'b0;
        dispatch_valid = 1'b0;
        alu_valid      = 1'b0;
        mul_valid      = 1'b0;
        div_valid      = 1'b0;
        mem_read       = 1'b0;
    endtask

    task automatic drive_wake(int src, phys_tag_t tag);
        alu_valid = (src == W_ALU);
        mul_valid = (src == W_MUL);
        div_valid = (src == W_DIV);
        mem_read  = (src == W_MEM);
        alu_tag   = (src == W_ALU) ? tag : ~tag;    // quiet buses carry another tag
        mul_tag   = (src == W_MUL) ? tag : ~tag;
        div_tag   = (src == W_DIV) ? tag : ~tag;
        mem_tag   = (src == W_MEM || src == W_MEM_NOREAD) ? tag : ~tag;
    endtask

    // a valid broadcast readies every held model entry with that tag
    task automatic model_wake(int src, phys_tag_t tag);
        if (src <= W_MEM) begin
            foreach (model_q[i]) begin
                if (model_q[i].e.op.src1 == tag) model_q[i].e.rdy1 = 1'b1;
                if (model_q[i].e.op.src2 == tag) model_q[i].e.rdy2 = 1'b1;
            end
        end
    endtask

    // oldest ready first and issued entries leave from the front
    task automatic model_pick();
        foreach (model_q[i]) begin
            if (!model_q[i].issued && model_q[i].e.rdy1 && model_q[i].e.rdy2) begin
                model_q[i].issued = 1'b1;
                exp_q.push_back(model_q[i].e.op);
                exp_name.push_back(model_q[i].name);
            end
        end
        while (model_q.size() > 0 && model_q[0].issued) begin
            model_q.delete(0);
        end
    endtask

    task automatic apply_row(row_t r);
        slot_t s;
        @(negedge clk);
        clear_inputs();
        case (r.kind)
            K_DISP: begin
                dispatch_valid = 1'b1;
                dispatch_pc    = r.ent.op.pc;
                dispatch_rd    = r.ent.op.rd;
                dispatch_aluop = r.ent.op.aluop;
                dispatch_src1  = r.ent.op.src1;
                dispatch_src2  = r.ent.op.src2;
                dispatch_rdy1  = r.ent.rdy1;
                dispatch_rdy2  = r.ent.rdy2;
                drive_wake(r.wsrc, r.wtag);
                if (model_q.size() < `RS_DEPTH) begin    // lost when full
                    s.e      = r.ent;
                    s.issued = 1'b0;
                    s.name   = r.name;
                    model_q.push_back(s);
                end
                model_wake(r.wsrc, r.wtag);
            end
            K_WAKE: begin
                drive_wake(r.wsrc, r.wtag);
                model_wake(r.wsrc, r.wtag);
            end
            K_FLUSH: begin
                flush = 1'b1;
                model_q.delete();
            end
            default: begin
                repeat (r.n - 1) @(negedge clk);
                check_full(r.name, model_q.size() == `RS_DEPTH, rs_full);
            end
        endcase
        model_pick();
    endtask

    always @(negedge clk) begin
        if (arst_n && issue_valid) begin
            if (exp_q.size() == 0) begin
                $display("issue of pc %h seen while no operation was ready", issue_pc);
                abort_run();
            end else begin
                check_issue(exp_name[0], exp_q[0], act_issue);
                exp_q.delete(0);
                exp_name.delete(0);
            end
        end
    end

    initial begin
        @(posedge arst_n);
        repeat (rows.size() * 20) @(posedge clk);
        $display("watchdog expired after %0d cycles", rows.size() * 20);
        abort_run();
    end

    initial begin
        arst_n         = 1'b0;
        dispatch_pc    = '0;
        dispatch_rd    = '0;
        dispatch_aluop = '0;
        dispatch_src1  = '0;
        dispatch_src2  = '0;
        dispatch_rdy1  = 1'b0;
        dispatch_rdy2  = 1'b0;
        drive_wake(W_NONE, 8'h00);
        clear_inputs();
        build_table();
        repeat (16) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        foreach (rows[i]) begin
            apply_row(rows[i]);
        end
        if (exp_q.size() != 0) begin
            $display("%0d expected issues never appeared, first is %s", exp_q.size(),
                     exp_name[0]);
            abort_run();
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule

// ==== include/rs_div_cfg.svh ====
`ifndef RS_DIV_CFG_SVH
`define RS_DIV_CFG_SVH

// station geometry
`define RS_DEPTH   16
`define RS_IDX_W   4
`define RS_WINDOW  16    // entries scanned from head

// operand and instruction fields
`define TAG_W      8
`define PC_W       32
`define OP_W       4

// result buses alu, mul, div and mem
`define WAKE_SRCS  4

`endif

// ==== rs_div.f ====
+incdir+include
src/rs_div_pkg.sv
src/rs_div_if.sv
src/rs_dispatch_stage.sv
src/rs_entry_array.sv
src/rs_issue_select.sv
src/rs_div_top.sv
dv/rs_div_tb.sv

// ==== src/rs_dispatch_stage.sv ====
module rs_dispatch_stage import rs_div_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  logic      flush,
    input  logic      in_valid,
    input  rs_entry_t in_entry,
    wake_if.snoop     wake,
    alloc_if.stage    alloc
);

    logic      valid_q;
    rs_entry_t entry_q;
    logic      hit1;
    logic      hit2;

    // broadcast in the dispatch cycle
    assign hit1 = wake_hit(wake.valid, wake.tag, in_entry.op.src1);
    assign hit2 = wake_hit(wake.valid, wake.tag, in_entry.op.src2);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else if (flush) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= in_valid && !alloc.full;    // dispatch while full is dropped
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            entry_q.op   <= in_entry.op;
            entry_q.rdy1 <= in_entry.rdy1 | hit1;
            entry_q.rdy2 <= in_entry.rdy2 | hit2;
        end
    end

    assign alloc.valid = valid_q;
    assign alloc.entry = entry_q;

endmodule

// ==== src/rs_div_if.sv ====
`include "rs_div_cfg.svh"

// result tag broadcast
interface wake_if import rs_div_pkg::*; ();
    logic [`WAKE_SRCS-1:0]      valid;    // one-cycle pulses
    phys_tag_t [`WAKE_SRCS-1:0] tag;

    modport src (
        output valid, tag
    );
    modport snoop (
        input valid, tag
    );
endinterface

// dispatch stage to entry array
interface alloc_if import rs_div_pkg::*; ();
    logic      valid;
    rs_entry_t entry;
    logic      full;

    modport stage (
        output valid, entry,
        input  full
    );
    modport array (
        input  valid, entry,
        output full
    );
endinterface

// entry array to issue select
interface sel_if import rs_div_pkg::*; ();
    logic [`RS_IDX_W-1:0]       head;
    logic [`RS_DEPTH-1:0]       ready;      // occupied, not issued, both sources ready
    rs_entry_t [`RS_DEPTH-1:0]  entries;
    logic                       issue_go;
    logic [`RS_IDX_W-1:0]       issue_idx;

    modport array (
        output head, ready, entries,
        input  issue_go, issue_idx
    );
    modport select (
        input  head, ready, entries,
        output issue_go, issue_idx
    );
endinterface

// ==== src/rs_div_pkg.sv ====
`include "rs_div_cfg.svh"

package rs_div_pkg;

    typedef logic [`TAG_W-1:0] phys_tag_t;

    typedef struct packed {
        logic [`PC_W-1:0] pc;
        phys_tag_t        rd;
        logic [`OP_W-1:0] aluop;
        phys_tag_t        src1;
        phys_tag_t        src2;
    } rs_op_t;            // 60 bits

    typedef struct packed {
        rs_op_t op;
        logic   rdy1;
        logic   rdy2;
    } rs_entry_t;

    typedef rs_op_t rs_issue_t;    // what the divider receives

    // true when any valid result bus carries tag
    function automatic logic wake_hit(
        input logic [`WAKE_SRCS-1:0]      vld,
        input phys_tag_t [`WAKE_SRCS-1:0] tags,
        input phys_tag_t                  tag
    );
        logic hit;
        hit = 1'b0;
        for (int s = 0; s < `WAKE_SRCS; s++) begin
            if (vld[s] && tags[s] == tag) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

endpackage

// ==== src/rs_div_top.sv ====
`include "rs_div_cfg.svh"

module rs_div_top import rs_div_pkg::*; (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             flush,
    input  logic             dispatch_valid,
    input  logic [`PC_W-1:0] dispatch_pc,
    input  logic [`TAG_W-1:0] dispatch_rd,
    input  logic [`OP_W-1:0] dispatch_aluop,
    input  logic [`TAG_W-1:0] dispatch_src1,
    input  logic [`TAG_W-1:0] dispatch_src2,
    input  logic             dispatch_rdy1,
    input  logic             dispatch_rdy2,
    input  logic             alu_valid,
    input  logic [`TAG_W-1:0] alu_tag,
    input  logic             mul_valid,
    input  logic [`TAG_W-1:0] mul_tag,
    input  logic             div_valid,
    input  logic [`TAG_W-1:0] div_tag,
    input  logic             mem_read,
    input  logic [`TAG_W-1:0] mem_tag,
    output logic             rs_full,
    output logic             issue_valid,
    output logic [`PC_W-1:0] issue_pc,
    output logic [`TAG_W-1:0] issue_rd,
    output logic [`OP_W-1:0] issue_aluop,
    output logic [`TAG_W-1:0] issue_src1,
    output logic [`TAG_W-1:0] issue_src2
);

    wake_if  wake ();
    alloc_if alloc ();
    sel_if   sel ();

    rs_entry_t in_entry;
    rs_issue_t issue;

    assign wake.valid = {mem_read, div_valid, mul_valid, alu_valid};
    assign wake.tag   = {mem_tag, div_tag, mul_tag, alu_tag};    // mem only counts with mem_read

    assign in_entry.op.pc    = dispatch_pc;
    assign in_entry.op.rd    = dispatch_rd;
    assign in_entry.op.aluop = dispatch_aluop;
    assign in_entry.op.src1  = dispatch_src1;
    assign in_entry.op.src2  = dispatch_src2;
    assign in_entry.rdy1     = dispatch_rdy1;
    assign in_entry.rdy2     = dispatch_rdy2;

    rs_dispatch_stage i_rs_dispatch_stage (
        .clk      (clk),
        .arst_n   (arst_n),
        .flush    (flush),
        .in_valid (dispatch_valid),
        .in_entry (in_entry),
        .wake     (wake.snoop),
        .alloc    (alloc.stage)
    );

    rs_entry_array i_rs_entry_array (
        .clk    (clk),
        .arst_n (arst_n),
        .flush  (flush),
        .wake   (wake.snoop),
        .alloc  (alloc.array),
        .sel    (sel.array)
    );

    rs_issue_select i_rs_issue_select (
        .clk         (clk),
        .arst_n      (arst_n),
        .flush       (flush),
        .sel         (sel.select),
        .issue_valid (issue_valid),
        .issue       (issue)
    );

    assign rs_full     = alloc.full;
    assign issue_pc    = issue.pc;
    assign issue_rd    = issue.rd;
    assign issue_aluop = issue.aluop;
    assign issue_src1  = issue.src1;
    assign issue_src2  = issue.src2;

endmodule

// ==== src/rs_entry_array.sv ====
`include "rs_div_cfg.svh"

module rs_entry_array import rs_div_pkg::*; (
    input  logic   clk,
    input  logic   arst_n,
    input  logic   flush,
    wake_if.snoop  wake,
    alloc_if.array alloc,
    sel_if.array   sel
);

    rs_entry_t [`RS_DEPTH-1:0] entries;
    logic [`RS_DEPTH-1:0]      occ;
    logic [`RS_DEPTH-1:0]      iss;
    logic [`RS_IDX_W-1:0]      head;
    logic [`RS_IDX_W-1:0]      tail;
    logic [`RS_IDX_W:0]        count;
    logic [`RS_IDX_W:0]        count_nxt;
    logic                      full;
    logic                      write;
    logic                      retire;
    rs_entry_t                 wr_entry;

    assign full   = (count == `RS_DEPTH);
    assign write  = alloc.valid && !full;
    assign retire = occ[head] && iss[head];    // issued entry at head leaves

    // a broadcast in the allocation cycle still counts
    always_comb begin
        wr_entry      = alloc.entry;
        wr_entry.rdy1 = alloc.entry.rdy1 | wake_hit(wake.valid, wake.tag, alloc.entry.op.src1);
        wr_entry.rdy2 = alloc.entry.rdy2 | wake_hit(wake.valid, wake.tag, alloc.entry.op.src2);
    end

    always_comb begin
        count_nxt = count;
        if (write) begin
            count_nxt = count_nxt + 1'b1;
        end
        if (retire) begin
            count_nxt = count_nxt - 1'b1;
        end
    end

    // payload and ready bits
    always_ff @(posedge clk) begin
        for (int i = 0; i < `RS_DEPTH; i++) begin
            if (write && tail == i[`RS_IDX_W-1:0]) begin
                entries[i] <= wr_entry;
            end else begin
                if (wake_hit(wake.valid, wake.tag, entries[i].op.src1)) begin
                    entries[i].rdy1 <= 1'b1;
                end
                if (wake_hit(wake.valid, wake.tag, entries[i].op.src2)) begin
                    entries[i].rdy2 <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            occ   <= '0;
            iss   <= '0;
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (flush) begin
            occ   <= '0;
            iss   <= '0;
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (write) begin
                occ[tail] <= 1'b1;
                iss[tail] <= 1'b0;
                tail      <= tail + 1'b1;
            end
            if (sel.issue_go) begin
                iss[sel.issue_idx] <= 1'b1;
            end
            if (retire) begin
                occ[head] <= 1'b0;
                head      <= head + 1'b1;
            end
            count <= count_nxt;
        end
    end

    always_comb begin
        for (int i = 0; i < `RS_DEPTH; i++) begin
            sel.ready[i] = occ[i] && !iss[i] && entries[i].rdy1 && entries[i].rdy2;
        end
    end

    assign sel.head    = head;
    assign sel.entries = entries;
    assign alloc.full  = full;

endmodule

// ==== src/rs_issue_select.sv ====
`include "rs_div_cfg.svh"

module rs_issue_select import rs_div_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  logic      flush,
    sel_if.select     sel,
    output logic      issue_valid,
    output rs_issue_t issue
);

    logic                 pick_vld;
    logic [`RS_IDX_W-1:0] pick_idx;

    // oldest ready entry scanning forward from head
    always_comb begin
        logic [`RS_IDX_W-1:0] idx;
        pick_vld = 1'b0;
        pick_idx = sel.head;
        for (int k = 0; k < `RS_WINDOW; k++) begin
            idx = sel.head + k[`RS_IDX_W-1:0];    // wraps at depth
            if (!pick_vld && sel.ready[idx]) begin
                pick_vld = 1'b1;
                pick_idx = idx;
            end
        end
    end

    assign sel.issue_go  = pick_vld;
    assign sel.issue_idx = pick_idx;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            issue_valid <= 1'b0;
        end else if (flush) begin
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= pick_vld;
        end
    end

    // operands to the divider
    always_ff @(posedge clk) begin
        if (pick_vld) begin
            issue <= sel.entries[pick_idx].op;
        end
    end

endmodule
